//--- build.f
+incdir+rtl
+incdir+verification
rtl/sw_pkg.sv
rtl/sw_cell.sv
rtl/sw_array.sv
rtl/sw_best_select.sv
rtl/sw_ctrl.sv
rtl/sw_core.sv
verification/tb_sw_core.sv

//--- Makefile
TOP := tb_sw_core

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module sw_core

clean:
	rm -rf obj_dir

//--- verification/sw_ref_model.svh
`ifndef SW_REF_MODEL_SVH
`define SW_REF_MODEL_SVH

// 16-bit Galois form, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic int max_of(input int a, input int b);
    return (a > b) ? a : b;
endfunction

function automatic int floor_zero(input int v);
    return (v > 0) ? v : 0;
endfunction

// full matrix, row is the read base and column the reference base
function automatic sw_result_t golden_align(input sw_job_t job);
    int m   [`SW_READ_LEN+1][`SW_REF_LEN+1];
    int ins [`SW_READ_LEN+1][`SW_REF_LEN+1];
    int del [`SW_READ_LEN+1][`SW_REF_LEN+1];
    int w;
    int s;
    int best;
    sw_result_t res;
    best = 0;
    res  = '0;
    for (int i = 0; i <= `SW_READ_LEN; i++) begin
        for (int j = 0; j <= `SW_REF_LEN; j++) begin
            m[i][j]   = 0;
            ins[i][j] = 0;
            del[i][j] = 0;
        end
    end
    for (int i = 1; i <= `SW_READ_LEN; i++) begin
        for (int j = 1; j <= `SW_REF_LEN; j++) begin
            w = (job.read_seq[i-1] == job.ref_seq[j-1]) ? `SW_MATCH : `SW_MISMATCH;
            ins[i][j] = floor_zero(max_of(m[i-1][j] + `SW_GAP_OPEN,
                                          ins[i-1][j] + `SW_GAP_EXTEND));
            del[i][j] = floor_zero(max_of(m[i][j-1] + `SW_GAP_OPEN,
                                          del[i][j-1] + `SW_GAP_EXTEND));
            m[i][j] = floor_zero(max_of(max_of(m[i-1][j-1], ins[i-1][j-1]),
                                        del[i-1][j-1]) + w);
            s = max_of(max_of(m[i][j], ins[i][j]), del[i][j]);
            // row-major scan, first column then smallest row wins
            if (s > best) begin
                best      = s;
                res.score = score_t'(s);
                res.row   = read_idx_t'(i - 1);
                res.col   = ref_idx_t'(j - 1);
            end
        end
    end
    return res;
endfunction

`endif

//--- verification/tb_sw_core.sv
`default_nettype none
`timescale 1ns/1ps
`include "sw_cfg.svh"

module tb_sw_core;
    import sw_pkg::*;

    `include "sw_ref_model.svh"

    localparam logic [15:0] LFSR_SEED    = 16'd77;
    localparam int          WAIT_LIMIT   = 200;
    localparam int          RANDOM_PAIRS = 20;

    logic       clk;
    logic       rst;
    logic       i_valid;
    logic       i_ready;
    sw_job_t    i_job;
    logic       o_ready;
    logic       o_valid;
    sw_result_t o_result;

    logic [15:0] lfsr;
    logic        test_ok;
    int          pass_cnt;
    int          fail_cnt;

    sw_core u_dut (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (i_valid),
        .i_job    (i_job),
        .o_ready  (o_ready),
        .o_valid  (o_valid),
        .o_result (o_result),
        .i_ready  (i_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one lfsr step per bit
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic sw_job_t random_job();
        sw_job_t job;
        for (int j = 0; j < `SW_REF_LEN; j++) begin
            job.ref_seq[j] = base_t'(take_bits(2));
        end
        for (int j = 0; j < `SW_READ_LEN; j++) begin
            job.read_seq[j] = base_t'(take_bits(2));
        end
        return job;
    endfunction

    task automatic check_field(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_result(input string name, input sw_result_t expected,
                                input sw_result_t actual);
        check_field({name, " score"}, int'(expected.score), int'(actual.score));
        check_field({name, " row"}, int'(expected.row), int'(actual.row));
        check_field({name, " col"}, int'(expected.col), int'(actual.col));
    endtask

    task automatic finish_test(input string name);
        if (test_ok) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: FAILED", name);
        end
        test_ok = 1'b1;
    endtask

    // polls o_valid or o_ready on falling edges
    task automatic wait_for(input logic want_valid, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!(want_valid ? o_valid : o_ready) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(want_valid ? o_valid : o_ready)) begin
            $display("timeout in %s: %s never rose", name, want_valid ? "o_valid" : "o_ready");
            test_ok = 1'b0;
        end
    endtask

    task automatic run_job(input string name, input sw_job_t job, input int hold,
                           output sw_result_t got);
        wait_for(1'b0, name);
        @(posedge clk);
        i_valid <= 1'b1;
        i_job   <= job;
        @(posedge clk);
        i_valid <= 1'b0;
        wait_for(1'b1, name);
        got = o_result;
        // result must hold while i_ready stays low
        for (int h = 0; h < hold; h++) begin
            @(negedge clk);
            check_field({name, " held o_valid"}, 1, int'(o_valid));
            check_field({name, " held o_ready"}, 0, int'(o_ready));
            check_field({name, " held o_result"}, int'(got), int'(o_result));
        end
        @(posedge clk);
        i_ready <= 1'b1;
        @(posedge clk);
        i_ready <= 1'b0;
        @(negedge clk);
        check_field({name, " o_valid after release"}, 0, int'(o_valid));
        check_field({name, " o_ready after release"}, 1, int'(o_ready));
    endtask

    initial begin
        sw_result_t got;
        sw_result_t exp_res;
        sw_job_t    job;
        int         hold;
        int         src;
        string      name;
        lfsr     = LFSR_SEED;
        test_ok  = 1'b1;
        pass_cnt = 0;
        fail_cnt = 0;
        rst      = 1'b1;
        i_valid  = 1'b0;
        i_ready  = 1'b0;
        i_job    = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_field("reset o_ready", 1, int'(o_ready));
        check_field("reset o_valid", 0, int'(o_valid));
        check_field("reset o_result", 0, int'(o_result));
        finish_test("reset");

        // exact full-length match ends in the corner cell
        job = random_job();
        job.read_seq = job.ref_seq;
        run_job("identical", job, 0, got);
        exp_res.score = score_t'(`SW_READ_LEN);
        exp_res.row   = read_idx_t'(`SW_READ_LEN - 1);
        exp_res.col   = ref_idx_t'(`SW_REF_LEN - 1);
        check_result("identical", exp_res, got);
        finish_test("identical");

        job.ref_seq  = '0;
        job.read_seq = '1;
        run_job("no match", job, 0, got);
        check_result("no match", '0, got);
        finish_test("no match");

        for (int t = 0; t < RANDOM_PAIRS; t++) begin
            name = $sformatf("random %0d", t);
            job  = random_job();
            run_job(name, job, 0, got);
            check_result(name, golden_align(job), got);
            finish_test(name);
        end

        job  = random_job();
        hold = 1 + int'(take_bits(5)) % 20;
        run_job("back-pressure", job, hold, got);
        check_result("back-pressure", golden_align(job), got);
        job = random_job();
        run_job("back-pressure next job", job, 0, got);
        check_result("back-pressure next job", golden_align(job), got);
        finish_test("back-pressure");

        // read copied from the reference, two reference bases skipped after base 7
        job = random_job();
        for (int p = 0; p < `SW_READ_LEN; p++) begin
            src = (p < 8) ? p : p + 2;
            if (src < `SW_REF_LEN) begin
                job.read_seq[p] = job.ref_seq[src];
            end
        end
        job.read_seq[3] = job.ref_seq[3] ^ 2'b01;
        run_job("planted", job, 0, got);
        check_result("planted", golden_align(job), got);
        finish_test("planted");

        $display("tests done: %0d ok, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/sw_core.sv
`default_nettype none
`timescale 1ns/1ps
`include "sw_cfg.svh"

module sw_core (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            i_valid,
    input  wire sw_pkg::sw_job_t i_job,
    output logic                 o_ready,
    output logic                 o_valid,
    output sw_pkg::sw_result_t   o_result,
    input  wire logic            i_ready
);
    import sw_pkg::*;

    logic      clear;
    logic      sweep_en;
    logic      scan_en;
    base_t     ref_base;
    read_seq_t read_seq;
    ref_idx_t  sweep_cnt;
    read_idx_t scan_row;
    score_t    row_best [`SW_READ_LEN];
    ref_idx_t  row_col  [`SW_READ_LEN];

    sw_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (i_valid),
        .i_job       (i_job),
        .i_ready     (i_ready),
        .o_ready     (o_ready),
        .o_clear     (clear),
        .o_sweep_en  (sweep_en),
        .o_ref_base  (ref_base),
        .o_read      (read_seq),
        .o_sweep_cnt (sweep_cnt),
        .o_scan_en   (scan_en),
        .o_scan_row  (scan_row),
        .o_done      (o_valid)
    );

    sw_array u_array (
        .clk         (clk),
        .rst         (rst),
        .i_clear     (clear),
        .i_sweep_en  (sweep_en),
        .i_ref_base  (ref_base),
        .i_read      (read_seq),
        .i_sweep_cnt (sweep_cnt),
        .o_row_best  (row_best),
        .o_row_col   (row_col)
    );

    sw_best_select u_select (
        .clk        (clk),
        .rst        (rst),
        .i_clear    (clear),
        .i_scan_en  (scan_en),
        .i_scan_row (scan_row),
        .i_row_best (row_best),
        .i_row_col  (row_col),
        .o_best     (o_result)
    );

endmodule

`default_nettype wire

//--- rtl/sw_ctrl.sv
`default_nettype none
`timescale 1ns/1ps
`include "sw_cfg.svh"

module sw_ctrl (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              i_valid,
    input  wire sw_pkg::sw_job_t   i_job,
    input  wire logic              i_ready,
    output logic                   o_ready,
    output logic                   o_clear,
    output logic                   o_sweep_en,
    output sw_pkg::base_t          o_ref_base,
    output sw_pkg::read_seq_t      o_read,
    output sw_pkg::ref_idx_t       o_sweep_cnt,
    output logic                   o_scan_en,
    output sw_pkg::read_idx_t      o_scan_row,
    output logic                   o_done
);
    import sw_pkg::*;

    typedef enum logic [2:0] {ST_IDLE, ST_LOAD, ST_SWEEP, ST_SCAN, ST_DONE} state_t;

    localparam ref_idx_t SWEEP_LAST = ref_idx_t'(`SW_REF_LEN + `SW_READ_LEN - 1);
    localparam ref_idx_t SCAN_LAST  = ref_idx_t'(`SW_READ_LEN - 1);

    state_t   state;
    state_t   state_nx;
    ref_idx_t cnt;
    ref_seq_t ref_shift;

    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE:  if (i_valid) state_nx = ST_LOAD;
            ST_LOAD:  state_nx = ST_SWEEP;
            ST_SWEEP: if (cnt == SWEEP_LAST) state_nx = ST_SCAN;
            ST_SCAN:  if (cnt == SCAN_LAST) state_nx = ST_DONE;
            ST_DONE:  if (i_ready) state_nx = ST_IDLE;
            default:  state_nx = ST_IDLE;
        endcase
    end

    // shared counter restarts at every state change
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nx;
            if (state_nx != state) begin
                cnt <= '0;
            end else if (state == ST_SWEEP || state == ST_SCAN) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // job taken on accept, reference drains head first
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_valid) begin
            o_read    <= i_job.read_seq;
            ref_shift <= i_job.ref_seq;
        end else if (state == ST_SWEEP) begin
            ref_shift <= ref_shift << $bits(base_t);
        end
    end

    assign o_ref_base  = ref_shift[0];
    assign o_sweep_cnt = cnt;
    assign o_scan_row  = read_idx_t'(cnt);
    assign o_ready     = (state == ST_IDLE);
    assign o_clear     = (state == ST_IDLE);
    assign o_sweep_en  = (state == ST_SWEEP);
    assign o_scan_en   = (state == ST_SCAN);
    assign o_done      = (state == ST_DONE);

endmodule

`default_nettype wire

//--- rtl/sw_best_select.sv
`default_nettype none
`timescale 1ns/1ps
`include "sw_cfg.svh"

module sw_best_select (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              i_clear,
    input  wire logic              i_scan_en,
    input  wire sw_pkg::read_idx_t i_scan_row,
    input  wire sw_pkg::score_t    i_row_best [`SW_READ_LEN],
    input  wire sw_pkg::ref_idx_t  i_row_col [`SW_READ_LEN],
    output sw_pkg::sw_result_t     o_best
);
    import sw_pkg::*;

    score_t   cand_score;
    ref_idx_t cand_col;

    // row under test this cycle
    assign cand_score = i_row_best[i_scan_row];
    assign cand_col   = i_row_col[i_scan_row];

    // smallest row wins a tie, nothing positive leaves all zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_best <= '0;
        end else if (i_clear) begin
            o_best <= '0;
        end else if (i_scan_en && (cand_score > o_best.score)) begin
            o_best.score <= cand_score;
            o_best.row   <= i_scan_row;
            o_best.col   <= cand_col;
        end
    end

endmodule

`default_nettype wire

//--- rtl/sw_array.sv
`default_nettype none
`timescale 1ns/1ps
`include "sw_cfg.svh"

module sw_array (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              i_clear,
    input  wire logic              i_sweep_en,
    input  wire sw_pkg::base_t     i_ref_base,
    input  wire sw_pkg::read_seq_t i_read,
    input  wire sw_pkg::ref_idx_t  i_sweep_cnt,
    output sw_pkg::score_t         o_row_best [`SW_READ_LEN],
    output sw_pkg::ref_idx_t       o_row_col [`SW_READ_LEN]
);
    import sw_pkg::*;

    sw_tracks_t trk    [`SW_READ_LEN];
    sw_tracks_t trk_d  [`SW_READ_LEN];
    sw_tracks_t trk_dd [`SW_READ_LEN];
    sw_tracks_t top    [`SW_READ_LEN];
    sw_tracks_t diag   [`SW_READ_LEN];
    score_t     score   [`SW_READ_LEN];
    score_t     score_q [`SW_READ_LEN];

    // entry k feeds cell k
    logic  ref_valid [`SW_READ_LEN+1];
    base_t ref_base  [`SW_READ_LEN+1];

    assign ref_valid[0] = i_sweep_en && (i_sweep_cnt < ref_idx_t'(`SW_REF_LEN));
    assign ref_base[0]  = i_ref_base;

    for (genvar k = 0; k < `SW_READ_LEN; k++) begin : g_row
        if (k == 0) begin : g_head
            // row above the first read base is all zero
            assign top[k]  = '0;
            assign diag[k] = '0;
        end else begin : g_link
            assign top[k]  = trk_d[k-1];
            assign diag[k] = trk_dd[k-1];
        end

        sw_cell u_cell (
            .clk          (clk),
            .rst          (rst),
            .i_ref_valid  (ref_valid[k]),
            .i_ref_base   (ref_base[k]),
            .i_read_valid (i_sweep_en),
            .i_read_base  (i_read[k]),
            .i_top        (top[k]),
            .i_diag       (diag[k]),
            .i_left       (trk_d[k]),
            .o_tracks     (trk[k]),
            .o_score      (score[k]),
            .o_ref_valid  (ref_valid[k+1]),
            .o_ref_base   (ref_base[k+1])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < `SW_READ_LEN; k++) begin
                trk_d[k]      <= '0;
                trk_dd[k]     <= '0;
                score_q[k]    <= '0;
                o_row_best[k] <= '0;
                o_row_col[k]  <= '0;
            end
        end else begin
            for (int k = 0; k < `SW_READ_LEN; k++) begin
                if (i_clear) begin
                    trk_d[k]      <= '0;
                    trk_dd[k]     <= '0;
                    score_q[k]    <= '0;
                    o_row_best[k] <= '0;
                    o_row_col[k]  <= '0;
                end else if (i_sweep_en) begin
                    trk_d[k]   <= trk[k];
                    trk_dd[k]  <= trk_d[k];
                    score_q[k] <= score[k];
                    // strict compare keeps the first column on a tie
                    if (score_q[k] > o_row_best[k]) begin
                        o_row_best[k] <= score_q[k];
                        o_row_col[k]  <= i_sweep_cnt - ref_idx_t'(k + 1);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/sw_cell.sv
`default_nettype none
`timescale 1ns/1ps
`include "sw_cfg.svh"

module sw_cell (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               i_ref_valid,
    input  wire sw_pkg::base_t      i_ref_base,
    input  wire logic               i_read_valid,
    input  wire sw_pkg::base_t      i_read_base,
    input  wire sw_pkg::sw_tracks_t i_top,
    input  wire sw_pkg::sw_tracks_t i_diag,
    input  wire sw_pkg::sw_tracks_t i_left,
    output sw_pkg::sw_tracks_t      o_tracks,
    output sw_pkg::score_t          o_score,
    output logic                    o_ref_valid,
    output sw_pkg::base_t           o_ref_base
);
    import sw_pkg::*;

    // one guard bit so sums cannot wrap before the clamp
    typedef logic signed [`SW_SCORE_W:0] wide_t;

    wide_t weight;

    function automatic wide_t max2(input wide_t a, input wide_t b);
        return (a > b) ? a : b;
    endfunction

    function automatic score_t clamp(input wide_t v);
        return (v > 0) ? score_t'(v) : '0;
    endfunction

    assign weight = (i_ref_base == i_read_base) ? wide_t'(`SW_MATCH) : wide_t'(`SW_MISMATCH);

    always_comb begin
        if (i_ref_valid && i_read_valid) begin
            // insert opens or extends from the row above
            o_tracks.ins = clamp(max2(wide_t'(i_top.align) + wide_t'(`SW_GAP_OPEN),
                                      wide_t'(i_top.ins) + wide_t'(`SW_GAP_EXTEND)));
            // delete from the previous column
            o_tracks.del = clamp(max2(wide_t'(i_left.align) + wide_t'(`SW_GAP_OPEN),
                                      wide_t'(i_left.del) + wide_t'(`SW_GAP_EXTEND)));
            o_tracks.align = clamp(max2(max2(i_diag.align, i_diag.ins), i_diag.del) + weight);
        end else begin
            // idle cell holds its last column
            o_tracks = i_left;
        end
    end

    assign o_score = clamp(max2(max2(o_tracks.align, o_tracks.ins), o_tracks.del));

    // reference base moves one cell per clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_ref_valid <= 1'b0;
        end else begin
            o_ref_valid <= i_ref_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_ref_base <= i_ref_base;
    end

endmodule

`default_nettype wire

//--- rtl/sw_pkg.sv
`default_nettype none
`include "sw_cfg.svh"

package sw_pkg;

    typedef logic [1:0] base_t;

    typedef logic signed [`SW_SCORE_W-1:0] score_t;

    // column index, also wide enough to count the whole sweep
    typedef logic [$clog2(`SW_REF_LEN + `SW_READ_LEN)-1:0] ref_idx_t;
    typedef logic [$clog2(`SW_READ_LEN)-1:0] read_idx_t;

    // base 0 lands in the most significant pair
    typedef base_t [0:`SW_REF_LEN-1] ref_seq_t;
    typedef base_t [0:`SW_READ_LEN-1] read_seq_t;

    typedef struct packed {
        ref_seq_t  ref_seq;
        read_seq_t read_seq;
    } sw_job_t;

    typedef struct packed {
        score_t align;
        score_t ins;
        score_t del;
    } sw_tracks_t;

    typedef struct packed {
        score_t    score;
        read_idx_t row;
        ref_idx_t  col;
    } sw_result_t;

endpackage

`default_nettype wire

//--- rtl/sw_cfg.svh
`ifndef SW_CFG_SVH
`define SW_CFG_SVH

// sequence lengths in bases
`define SW_REF_LEN      16
`define SW_READ_LEN     16

// signed score width
`define SW_SCORE_W      10

// linear weights
`define SW_MATCH        1
`define SW_MISMATCH     (-4)

// affine gap penalties
`define SW_GAP_OPEN     (-6)
`define SW_GAP_EXTEND   (-1)

`endif
